//--- hdl/decode_pkg.sv
// RV64I decode definitions
`default_nettype none

package decode_pkg;

    localparam int xlen = 64;
    localparam int ilen = 32;
    localparam int shamt_w = 6;

    typedef logic [4:0] reg_idx_t;
    typedef logic [6:0] opcode_t;
    typedef logic [7:0] instr_type_t;
    typedef logic [1:0] mem_size_t;  // log2 of the byte count

    // Major opcodes
    localparam opcode_t op_reg    = 7'b0110011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_reg_w  = 7'b0111011;
    localparam opcode_t op_imm_w  = 7'b0011011;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_system = 7'b1110011;

    // Instruction type codes
    localparam instr_type_t ty_add    = 8'd0;
    localparam instr_type_t ty_sub    = 8'd1;
    localparam instr_type_t ty_xor    = 8'd2;
    localparam instr_type_t ty_or     = 8'd3;
    localparam instr_type_t ty_and    = 8'd4;
    localparam instr_type_t ty_sll    = 8'd5;
    localparam instr_type_t ty_srl    = 8'd6;
    localparam instr_type_t ty_sra    = 8'd7;
    localparam instr_type_t ty_slt    = 8'd8;
    localparam instr_type_t ty_sltu   = 8'd9;
    localparam instr_type_t ty_addi   = 8'd18;
    localparam instr_type_t ty_xori   = 8'd19;
    localparam instr_type_t ty_ori    = 8'd20;
    localparam instr_type_t ty_andi   = 8'd21;
    localparam instr_type_t ty_slli   = 8'd22;
    localparam instr_type_t ty_srli   = 8'd23;
    localparam instr_type_t ty_srai   = 8'd24;
    localparam instr_type_t ty_slti   = 8'd25;
    localparam instr_type_t ty_sltiu  = 8'd26;
    localparam instr_type_t ty_addiw  = 8'd29;
    localparam instr_type_t ty_slliw  = 8'd30;
    localparam instr_type_t ty_srliw  = 8'd31;
    localparam instr_type_t ty_sraiw  = 8'd32;
    localparam instr_type_t ty_addw   = 8'd33;
    localparam instr_type_t ty_subw   = 8'd34;
    localparam instr_type_t ty_sllw   = 8'd35;
    localparam instr_type_t ty_srlw   = 8'd36;
    localparam instr_type_t ty_sraw   = 8'd37;
    localparam instr_type_t ty_sb     = 8'd43;
    localparam instr_type_t ty_sh     = 8'd44;
    localparam instr_type_t ty_sw     = 8'd45;
    localparam instr_type_t ty_sd     = 8'd46;
    localparam instr_type_t ty_beq    = 8'd47;
    localparam instr_type_t ty_bne    = 8'd48;
    localparam instr_type_t ty_blt    = 8'd49;
    localparam instr_type_t ty_bge    = 8'd50;
    localparam instr_type_t ty_bltu   = 8'd51;
    localparam instr_type_t ty_bgeu   = 8'd52;
    localparam instr_type_t ty_jal    = 8'd53;
    localparam instr_type_t ty_jalr   = 8'd54;
    localparam instr_type_t ty_lui    = 8'd55;
    localparam instr_type_t ty_auipc  = 8'd56;
    localparam instr_type_t ty_ecall  = 8'd57;
    localparam instr_type_t ty_ebreak = 8'd58;
    localparam instr_type_t ty_lb     = 8'd59;
    localparam instr_type_t ty_lh     = 8'd60;
    localparam instr_type_t ty_lw     = 8'd61;
    localparam instr_type_t ty_lbu    = 8'd62;
    localparam instr_type_t ty_lhu    = 8'd63;
    localparam instr_type_t ty_lwu    = 8'd64;
    localparam instr_type_t ty_ld     = 8'd65;
    localparam instr_type_t type_unknown = 8'd255;

    typedef struct packed {
        opcode_t                opcode;
        reg_idx_t               rd;
        reg_idx_t               rs1;
        reg_idx_t               rs2;
        logic signed [xlen-1:0] imm;
        logic [shamt_w-1:0]     shamt;
        instr_type_t            instr_type;
        mem_size_t              data_size;
        logic                   read_mem;
        logic                   write_mem;
        logic                   illegal;
        logic [xlen-1:0]        next_pc;   // pc + 4
    } decoded_t;

endpackage

`default_nettype wire

//--- hdl/fields_if.sv
// Instruction field bundle
`timescale 1ns/1ps
`default_nettype none

interface fields_if import decode_pkg::*; ();

    logic [ilen-1:0] word;     // Raw held instruction
    opcode_t         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    reg_idx_t        rd;       // Already zeroed per format
    reg_idx_t        rs1;
    reg_idx_t        rs2;

    modport src (
        output word, opcode, funct3, funct7, rd, rs1, rs2
    );

    modport cls (
        input word, opcode, funct3, funct7
    );

endinterface

`default_nettype wire

//--- hdl/decode_ctrl.sv
// Decode sequencing FSM
`timescale 1ns/1ps
`default_nettype none

module decode_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic decode_enable,
    input  logic register_values_ready,
    output logic capture,
    output logic commit,
    output logic decode_complete
);

    typedef enum logic {
        idle,
        wait_operands
    } state_t;

    state_t state;

    // Enables while busy are dropped here
    assign capture = (state == idle) && decode_enable;
    assign commit  = (state == wait_operands) && register_values_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state           <= idle;
            decode_complete <= 1'b0;
        end else begin
            decode_complete <= commit;  // Lines up with the registered result
            case (state)
                idle: begin
                    if (capture) begin
                        state <= wait_operands;
                    end
                end
                wait_operands: begin
                    if (commit) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/field_decode.sv
// Register field and immediate extraction
`timescale 1ns/1ps
`default_nettype none

module field_decode import decode_pkg::*; (
    input  logic [ilen-1:0]        instr,
    fields_if.src                  f,
    output logic signed [xlen-1:0] imm,
    output logic [shamt_w-1:0]     shamt
);

    opcode_t op;
    logic    sign;

    assign op   = instr[6:0];
    assign sign = instr[31];   // Every immediate format keeps its sign here

    assign f.word   = instr;
    assign f.opcode = op;
    assign f.funct3 = instr[14:12];
    assign f.funct7 = instr[31:25];

    always_comb begin
        f.rd  = instr[11:7];
        f.rs1 = instr[19:15];
        f.rs2 = instr[24:20];
        if (op == op_store || op == op_branch || op == op_system) begin
            f.rd = '0;
        end
        if (op == op_jal || op == op_lui || op == op_auipc || op == op_system) begin
            f.rs1 = '0;
        end
        if (!(op == op_reg || op == op_reg_w || op == op_store || op == op_branch)) begin
            f.rs2 = '0;
        end
    end

    always_comb begin
        case (op)
            op_imm, op_imm_w, op_load, op_jalr, op_system:
                imm = {{52{sign}}, instr[31:20]};
            op_store:
                imm = {{52{sign}}, instr[31:25], instr[11:7]};
            op_branch:
                imm = {{52{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            op_jal:
                imm = {{44{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            op_lui, op_auipc:
                imm = {{32{sign}}, instr[31:12], 12'b0};
            default:
                imm = '0;   // R, W and unknown
        endcase
    end

    // funct3 of 001 and 101 are the shifts
    always_comb begin
        shamt = '0;
        if (op == op_imm && instr[13:12] == 2'b01) begin
            shamt = instr[25:20];
        end else if (op == op_imm_w && instr[13:12] == 2'b01) begin
            shamt = {1'b0, instr[24:20]};  // Word shifts stop at 31
        end
    end

endmodule

`default_nettype wire

//--- hdl/op_classify.sv
// Instruction type classification
`timescale 1ns/1ps
`default_nettype none

module op_classify import decode_pkg::*; (
    fields_if.cls       f,
    output instr_type_t instr_type,
    output mem_size_t   data_size,
    output logic        read_mem,
    output logic        write_mem,
    output logic        illegal
);

    logic        f7_zero;
    logic        f7_alt;
    logic [5:0]  shift_sel;
    instr_type_t ty;

    assign f7_zero   = f.funct7 == 7'b0000000;
    assign f7_alt    = f.funct7 == 7'b0100000;  // SUB and arithmetic shifts
    assign shift_sel = f.word[31:26];           // RV64 shifts give up bit 25

    always_comb begin
        ty = type_unknown;
        case (f.opcode)
            op_reg: begin
                case (f.funct3)
                    3'b000:  ty = f7_zero ? ty_add : (f7_alt ? ty_sub : type_unknown);
                    3'b001:  ty = f7_zero ? ty_sll : type_unknown;
                    3'b010:  ty = f7_zero ? ty_slt : type_unknown;
                    3'b011:  ty = f7_zero ? ty_sltu : type_unknown;
                    3'b100:  ty = f7_zero ? ty_xor : type_unknown;
                    3'b101:  ty = f7_zero ? ty_srl : (f7_alt ? ty_sra : type_unknown);
                    3'b110:  ty = f7_zero ? ty_or : type_unknown;
                    default: ty = f7_zero ? ty_and : type_unknown;
                endcase
            end
            op_imm: begin
                case (f.funct3)
                    3'b000:  ty = ty_addi;
                    3'b001:  ty = (shift_sel == 6'b000000) ? ty_slli : type_unknown;
                    3'b010:  ty = ty_slti;
                    3'b011:  ty = ty_sltiu;
                    3'b100:  ty = ty_xori;
                    3'b101:  ty = (shift_sel == 6'b000000) ? ty_srli :
                                  (shift_sel == 6'b010000) ? ty_srai : type_unknown;
                    3'b110:  ty = ty_ori;
                    default: ty = ty_andi;
                endcase
            end
            op_imm_w: begin
                case (f.funct3)
                    3'b000:  ty = ty_addiw;
                    3'b001:  ty = f7_zero ? ty_slliw : type_unknown;
                    3'b101:  ty = f7_zero ? ty_srliw : (f7_alt ? ty_sraiw : type_unknown);
                    default: ty = type_unknown;
                endcase
            end
            op_reg_w: begin
                case (f.funct3)
                    3'b000:  ty = f7_zero ? ty_addw : (f7_alt ? ty_subw : type_unknown);
                    3'b001:  ty = f7_zero ? ty_sllw : type_unknown;
                    3'b101:  ty = f7_zero ? ty_srlw : (f7_alt ? ty_sraw : type_unknown);
                    default: ty = type_unknown;  // M extension lands here
                endcase
            end
            op_load: begin
                case (f.funct3)
                    3'b000:  ty = ty_lb;
                    3'b001:  ty = ty_lh;
                    3'b010:  ty = ty_lw;
                    3'b011:  ty = ty_ld;
                    3'b100:  ty = ty_lbu;
                    3'b101:  ty = ty_lhu;
                    3'b110:  ty = ty_lwu;
                    default: ty = type_unknown;
                endcase
            end
            op_store: begin
                case (f.funct3)
                    3'b000:  ty = ty_sb;
                    3'b001:  ty = ty_sh;
                    3'b010:  ty = ty_sw;
                    3'b011:  ty = ty_sd;
                    default: ty = type_unknown;
                endcase
            end
            op_branch: begin
                case (f.funct3)
                    3'b000:  ty = ty_beq;
                    3'b001:  ty = ty_bne;
                    3'b100:  ty = ty_blt;
                    3'b101:  ty = ty_bge;
                    3'b110:  ty = ty_bltu;
                    3'b111:  ty = ty_bgeu;
                    default: ty = type_unknown;
                endcase
            end
            op_jal:   ty = ty_jal;
            op_jalr:  ty = ty_jalr;     // funct3 not checked
            op_lui:   ty = ty_lui;
            op_auipc: ty = ty_auipc;
            op_system: begin
                if (f.funct3 == 3'b000 && f.word[31:20] == 12'h000) begin
                    ty = ty_ecall;
                end else if (f.funct3 == 3'b000 && f.word[31:20] == 12'h001) begin
                    ty = ty_ebreak;
                end
            end
            default: ty = type_unknown;
        endcase
    end

    assign instr_type = ty;
    assign illegal    = ty == type_unknown;

    // funct3[1:0] is already log2 of the access bytes
    assign read_mem  = !illegal && f.opcode == op_load;
    assign write_mem = !illegal && f.opcode == op_store;
    assign data_size = (read_mem || write_mem) ? f.funct3[1:0] : '0;

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
// Instruction hold and result register
`timescale 1ns/1ps
`default_nettype none

module decode_stage import decode_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            capture,
    input  logic            commit,
    input  logic [xlen-1:0] pc_current,
    input  logic [ilen-1:0] instruction,
    output decoded_t        result
);

    logic [ilen-1:0]        instr_q;
    logic [xlen-1:0]        pc_q;
    logic signed [xlen-1:0] imm;
    logic [shamt_w-1:0]     shamt;
    instr_type_t            instr_type;
    mem_size_t              data_size;
    logic                   read_mem;
    logic                   write_mem;
    logic                   illegal;
    decoded_t               next_result;

    fields_if fields ();

    field_decode u_field_decode (
        .instr (instr_q),
        .f     (fields),
        .imm   (imm),
        .shamt (shamt)
    );

    op_classify u_op_classify (
        .f          (fields),
        .instr_type (instr_type),
        .data_size  (data_size),
        .read_mem   (read_mem),
        .write_mem  (write_mem),
        .illegal    (illegal)
    );

    always_ff @(posedge clk) begin
        if (capture) begin
            instr_q <= instruction;
            pc_q    <= pc_current;
        end
    end

    always_comb begin
        next_result.opcode     = fields.opcode;
        next_result.rd         = fields.rd;
        next_result.rs1        = fields.rs1;
        next_result.rs2        = fields.rs2;
        next_result.imm        = imm;
        next_result.shamt      = shamt;
        next_result.instr_type = instr_type;
        next_result.data_size  = data_size;
        next_result.read_mem   = read_mem;
        next_result.write_mem  = write_mem;
        next_result.illegal    = illegal;
        next_result.next_pc    = pc_q + xlen'(4);  // Fall-through address
    end

    // Holds until the next commit
    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else if (commit) begin
            result <= next_result;
        end
    end

endmodule

`default_nettype wire

//--- hdl/decoder_top.sv
// RV64I decode stage top
`timescale 1ns/1ps
`default_nettype none

module decoder_top import decode_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   decode_enable,
    input  logic [xlen-1:0]        pc_current,
    input  logic [ilen-1:0]        instruction,
    input  logic                   register_values_ready,
    output opcode_t                opcode,
    output reg_idx_t               rd,
    output reg_idx_t               rs1,
    output reg_idx_t               rs2,
    output logic signed [xlen-1:0] imm,
    output logic [shamt_w-1:0]     shamt,
    output instr_type_t            instr_type,
    output mem_size_t              data_size,
    output logic                   read_mem,
    output logic                   write_mem,
    output logic                   illegal,
    output logic [xlen-1:0]        next_pc,
    output logic                   decode_complete
);

    logic     capture;
    logic     commit;
    decoded_t result;

    decode_ctrl u_decode_ctrl (
        .clk                   (clk),
        .reset                 (reset),
        .decode_enable         (decode_enable),
        .register_values_ready (register_values_ready),
        .capture               (capture),
        .commit                (commit),
        .decode_complete       (decode_complete)
    );

    decode_stage u_decode_stage (
        .clk         (clk),
        .reset       (reset),
        .capture     (capture),
        .commit      (commit),
        .pc_current  (pc_current),
        .instruction (instruction),
        .result      (result)
    );

    assign opcode     = result.opcode;
    assign rd         = result.rd;
    assign rs1        = result.rs1;
    assign rs2        = result.rs2;
    assign imm        = result.imm;
    assign shamt      = result.shamt;
    assign instr_type = result.instr_type;
    assign data_size  = result.data_size;
    assign read_mem   = result.read_mem;
    assign write_mem  = result.write_mem;
    assign illegal    = result.illegal;
    assign next_pc    = result.next_pc;

endmodule

`default_nettype wire

//--- tb/decoder_assert.sv
// Decode control assertions
`timescale 1ns/1ps
`default_nettype none

module decoder_assert (
    input logic clk,
    input logic reset,
    input logic capture,
    input logic commit,
    input logic decode_complete
);

    logic pending;  // Word captured and not yet committed

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (capture) begin
            pending <= 1'b1;
        end else if (commit) begin
            pending <= 1'b0;
        end
    end

    a_complete_one_cycle: assert property (
        @(posedge clk) disable iff (reset) decode_complete |=> !decode_complete
    ) else $error("decode_complete stayed high for more than one cycle");

    // A second enable during a decode must not capture
    a_no_capture_while_busy: assert property (
        @(posedge clk) disable iff (reset) capture |-> !pending
    ) else $error("capture accepted while a decode was still pending");

    // Commit only while operands are awaited
    a_commit_in_wait: assert property (
        @(posedge clk) disable iff (reset) commit |-> pending
    ) else $error("commit raised with no decode pending");

endmodule

bind decode_ctrl decoder_assert u_decoder_assert (
    .clk             (clk),
    .reset           (reset),
    .capture         (capture),
    .commit          (commit),
    .decode_complete (decode_complete)
);

`default_nettype wire

//--- tb/tb_decoder.sv
// RV64I decoder testbench
`timescale 1ns/1ps
`default_nettype none

module tb_decoder import decode_pkg::*; ();

    logic                   clk;
    logic                   reset;
    logic                   decode_enable;
    logic [xlen-1:0]        pc_current;
    logic [ilen-1:0]        instruction;
    logic                   register_values_ready;
    opcode_t                opcode;
    reg_idx_t               rd;
    reg_idx_t               rs1;
    reg_idx_t               rs2;
    logic signed [xlen-1:0] imm;
    logic [shamt_w-1:0]     shamt;
    instr_type_t            instr_type;
    mem_size_t              data_size;
    logic                   read_mem;
    logic                   write_mem;
    logic                   illegal;
    logic [xlen-1:0]        next_pc;
    logic                   decode_complete;
    logic [31:0]            seed = 32'h36a1;

    decoder_top UUT (
        .clk (clk), .reset (reset), .decode_enable (decode_enable),
        .pc_current (pc_current), .instruction (instruction),
        .register_values_ready (register_values_ready),
        .opcode (opcode), .rd (rd), .rs1 (rs1), .rs2 (rs2), .imm (imm), .shamt (shamt),
        .instr_type (instr_type), .data_size (data_size), .read_mem (read_mem),
        .write_mem (write_mem), .illegal (illegal), .next_pc (next_pc),
        .decode_complete (decode_complete)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int rand_range(input int n);
        return int'((next_rand() >> 8) % 32'(n));  // Low bits of an LCG cycle fast
    endfunction

    function automatic opcode_t pick_opcode(input int i);
        case (i)
            0: return op_reg;
            1: return op_imm;
            2: return op_reg_w;
            3: return op_imm_w;
            4: return op_load;
            5: return op_store;
            6: return op_branch;
            7: return op_jal;
            8: return op_jalr;
            9: return op_lui;
            10: return op_auipc;
            default: return op_system;
        endcase
    endfunction

    function automatic logic [31:0] gen_word();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] w;
        int          sel;
        r1 = next_rand();
        r2 = next_rand();
        w  = {r1[31:16], r2[31:16]};
        if (rand_range(16) == 0) begin
            w[6:0] = r1[14:8];  // Any opcode at all
        end else begin
            w[6:0] = pick_opcode(rand_range(12));
        end
        sel = rand_range(8);
        if (sel == 0) begin
            w[31:25] = 7'b0100000;
        end else if (sel == 1) begin
            w[31:25] = 7'b0000001;  // M extension pattern
        end else if (sel < 4) begin
            w[31:25] = 7'b0000000;
        end
        // Steer half the system words near ECALL and EBREAK
        if (w[6:0] == op_system && rand_range(2) == 0) begin
            w[31:21] = '0;
            w[14:12] = 3'b000;
        end
        return w;
    endfunction

    function automatic logic [63:0] sign_extend(input logic [63:0] v, input int bits);
        logic [63:0] r;
        int          i;
        r = v;
        for (i = bits; i < 64; i++) begin
            r[i] = v[bits-1];
        end
        return r;
    endfunction

    // Expected type code from the opcode and function fields
    function automatic int class_code(input logic [31:0] w);
        logic [6:0] op;
        logic [2:0] f3;
        logic       z7;
        logic       a7;
        op = w[6:0];
        f3 = w[14:12];
        z7 = w[31:25] == 7'b0000000;
        a7 = w[31:25] == 7'b0100000;
        case (op)
            op_reg: begin
                if (z7) begin
                    case (f3)
                        3'd0: return 0;
                        3'd1: return 5;
                        3'd2: return 8;
                        3'd3: return 9;
                        3'd4: return 2;
                        3'd5: return 6;
                        3'd6: return 3;
                        default: return 4;
                    endcase
                end
                if (a7 && f3 == 3'd0) return 1;
                if (a7 && f3 == 3'd5) return 7;
            end
            op_imm: begin
                case (f3)
                    3'd0: return 18;
                    3'd1: return (w[31:26] == 6'd0) ? 22 : 255;
                    3'd2: return 25;
                    3'd3: return 26;
                    3'd4: return 19;
                    3'd5: return (w[31:26] == 6'd0) ? 23 : ((w[31:26] == 6'b010000) ? 24 : 255);
                    3'd6: return 20;
                    default: return 21;
                endcase
            end
            op_imm_w: begin
                if (f3 == 3'd0) return 29;
                if (f3 == 3'd1 && z7) return 30;
                if (f3 == 3'd5 && z7) return 31;
                if (f3 == 3'd5 && a7) return 32;
            end
            op_reg_w: begin
                if (f3 == 3'd0 && z7) return 33;
                if (f3 == 3'd0 && a7) return 34;
                if (f3 == 3'd1 && z7) return 35;
                if (f3 == 3'd5 && z7) return 36;
                if (f3 == 3'd5 && a7) return 37;
            end
            op_load: begin
                case (f3)
                    3'd0: return 59;
                    3'd1: return 60;
                    3'd2: return 61;
                    3'd3: return 65;
                    3'd4: return 62;
                    3'd5: return 63;
                    3'd6: return 64;
                    default: return 255;
                endcase
            end
            op_store: if (f3 < 3'd4) return 43 + int'(f3);
            op_branch: begin
                case (f3)
                    3'd0: return 47;
                    3'd1: return 48;
                    3'd4: return 49;
                    3'd5: return 50;
                    3'd6: return 51;
                    3'd7: return 52;
                    default: return 255;
                endcase
            end
            op_jal: return 53;
            op_jalr: return 54;
            op_lui: return 55;
            op_auipc: return 56;
            op_system: begin
                if (f3 == 3'd0 && w[31:20] == 12'd0) return 57;
                if (f3 == 3'd0 && w[31:20] == 12'd1) return 58;
            end
            default: return 255;
        endcase
        return 255;
    endfunction

    function automatic decoded_t model_decode(input logic [31:0] w, input logic [63:0] pc);
        decoded_t   d;
        logic [6:0] op;
        logic [2:0] f3;
        d  = '0;
        op = w[6:0];
        f3 = w[14:12];
        d.opcode = op;
        d.rd  = (op == op_store || op == op_branch || op == op_system) ? 5'd0 : w[11:7];
        d.rs1 = (op == op_jal || op == op_lui || op == op_auipc || op == op_system) ?
                5'd0 : w[19:15];
        d.rs2 = (op == op_reg || op == op_reg_w || op == op_store || op == op_branch) ?
                w[24:20] : 5'd0;
        case (op)
            op_imm, op_imm_w, op_load, op_jalr, op_system:
                d.imm = sign_extend(64'(w[31:20]), 12);
            op_store:
                d.imm = sign_extend(64'({w[31:25], w[11:7]}), 12);
            op_branch:
                d.imm = sign_extend(64'({w[31], w[7], w[30:25], w[11:8], 1'b0}), 13);
            op_jal:
                d.imm = sign_extend(64'({w[31], w[19:12], w[20], w[30:21], 1'b0}), 21);
            op_lui, op_auipc:
                d.imm = sign_extend(64'({w[31:12], 12'h000}), 32);
            default:
                d.imm = '0;
        endcase
        if (op == op_imm && (f3 == 3'b001 || f3 == 3'b101)) begin
            d.shamt = w[25:20];
        end else if (op == op_imm_w && (f3 == 3'b001 || f3 == 3'b101)) begin
            d.shamt = {1'b0, w[24:20]};
        end
        d.instr_type = 8'(class_code(w));
        d.illegal    = d.instr_type == 8'd255;
        d.read_mem   = !d.illegal && op == op_load;
        d.write_mem  = !d.illegal && op == op_store;
        d.data_size  = (d.read_mem || d.write_mem) ? f3[1:0] : 2'd0;
        d.next_pc    = pc + 64'd4;
        return d;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("Mismatch in %s: expected 0x%0h, actual 0x%0h",
                                name, expected, actual));
        end
    endtask

    task automatic check_outputs(input string tag, input decoded_t e);
        check_value({tag, " opcode"}, 64'(e.opcode), 64'(opcode));
        check_value({tag, " rd"}, 64'(e.rd), 64'(rd));
        check_value({tag, " rs1"}, 64'(e.rs1), 64'(rs1));
        check_value({tag, " rs2"}, 64'(e.rs2), 64'(rs2));
        check_value({tag, " imm"}, 64'(e.imm), 64'(imm));
        check_value({tag, " shamt"}, 64'(e.shamt), 64'(shamt));
        check_value({tag, " instr_type"}, 64'(e.instr_type), 64'(instr_type));
        check_value({tag, " illegal"}, 64'(e.illegal), 64'(illegal));
        check_value({tag, " data_size"}, 64'(e.data_size), 64'(data_size));
        check_value({tag, " read_mem"}, 64'(e.read_mem), 64'(read_mem));
        check_value({tag, " write_mem"}, 64'(e.write_mem), 64'(write_mem));
        check_value({tag, " next_pc"}, e.next_pc, next_pc);
    endtask

    // One decode with a chosen operand delay and an optional second enable
    task automatic run_decode(input int n, input logic [31:0] w, input logic [63:0] pc,
                              input int delay, input bit extra,
                              input decoded_t prev_d, input decoded_t want_d);
        int    cycles;
        bit    done;
        string tag;
        tag = $sformatf("decode %0d (word %08h)", n, w);
        @(posedge clk);
        decode_enable         <= 1'b1;
        instruction           <= w;
        pc_current            <= pc;
        register_values_ready <= rand_range(2) == 1;  // Ignored while idle
        @(posedge clk);                               // Capture edge
        decode_enable <= extra;
        if (extra) begin
            instruction <= ~w;
            pc_current  <= pc + 64'd64;
        end
        register_values_ready <= (delay == 0);
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(posedge clk);
            cycles++;
            decode_enable         <= 1'b0;
            register_values_ready <= (cycles >= delay);
            @(negedge clk);
            if (decode_complete) begin
                done = 1'b1;
            end else begin
                check_outputs({tag, " hold"}, prev_d);
                if (cycles >= 20) begin
                    abort_run({"Timeout: decode_complete never arrived for ", tag});
                end
            end
        end
        check_value({tag, " latency"}, 64'(delay + 1), 64'(cycles));
        check_outputs(tag, want_d);
        @(posedge clk);
        register_values_ready <= 1'b0;
        @(negedge clk);
        check_value({tag, " decode_complete drop"}, 64'd0, 64'(decode_complete));
        check_outputs({tag, " after"}, want_d);
    endtask

    initial begin
        decoded_t    prev_d;
        decoded_t    want_d;
        logic [31:0] w;
        logic [63:0] pc;
        int          delay;
        bit          extra;
        clk                   = 1'b0;
        reset                 = 1'b1;
        decode_enable         = 1'b0;
        pc_current            = '0;
        instruction           = '0;
        register_values_ready = 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        prev_d = '0;  // Reset state of every output
        check_value("reset decode_complete", 64'd0, 64'(decode_complete));
        check_outputs("reset", prev_d);
        for (int n = 0; n < 400; n++) begin
            w      = gen_word();
            pc     = {next_rand(), next_rand()};
            pc[1:0] = 2'b00;
            delay  = rand_range(7);
            extra  = rand_range(4) == 0;
            want_d = model_decode(w, pc);
            run_decode(n, w, pc, delay, extra, prev_d, want_d);
            prev_d = want_d;
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
hdl/decode_pkg.sv
hdl/fields_if.sv
hdl/decode_ctrl.sv
hdl/field_decode.sv
hdl/op_classify.sv
hdl/decode_stage.sv
hdl/decoder_top.sv
tb/decoder_assert.sv
tb/tb_decoder.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the decoder testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_decoder -o tb_decoder_sim &&
    ./obj_dir/tb_decoder_sim > sim.log 2>&1 ||
    echo "Build or simulation returned an error"

cat sim.log 2>/dev/null
grep -qx "TESTBENCH PASSED" sim.log && echo "Result: pass" || { echo "Result: fail"; exit 1; }
